//--- design/desc_completion.sv
// drains the request buffer into the DMA engine and writes back completions
// outstanding requests are tracked in order; each done triggers one writeback
`timescale 1ns/1ps
`include "desc_dma_consts.svh"

module desc_completion (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  desc_dma_pkg::buf_entry_t buf_entry_i,
    input  logic                     buf_empty_i,
    output logic                     buf_pop_o,
    output logic                     credit_ret_o,
    output logic                     dma_req_valid_o,
    output desc_dma_pkg::addr_t      dma_req_src_o,
    output desc_dma_pkg::addr_t      dma_req_dst_o,
    output desc_dma_pkg::len_t       dma_req_len_o,
    input  logic                     dma_req_ready_i,
    input  logic                     dma_done_i,
    output logic                     wb_valid_o,
    output desc_dma_pkg::addr_t      wb_addr_o,
    input  logic                     wb_ready_i,
    output logic                     irq_o,
    output logic                     busy_o
);

    localparam int unsigned DONE_W = $clog2(`DESC_TRACK_DEPTH + 1);

    desc_dma_pkg::dma_req_t req_q;
    logic                   req_valid_q;
    desc_dma_pkg::track_t   trk_head;
    logic                   trk_full;
    logic                   trk_empty;
    logic                   trk_pop;
    logic [DONE_W-1:0]      done_cnt_q;
    logic                   wb_valid_q;
    logic                   wb_irq_q;
    desc_dma_pkg::addr_t    wb_addr_q;
    logic                   wb_free;

    // take the next entry only with the request slot and a tracking slot free
    assign buf_pop_o    = !buf_empty_i && !req_valid_q && !trk_full;
    assign credit_ret_o = buf_pop_o;

    // writeback register may be reloaded in the cycle it hands off
    assign wb_free = !wb_valid_q || wb_ready_i;
    // a done this cycle or one parked in the counter
    assign trk_pop = wb_free && !trk_empty && (dma_done_i || (done_cnt_q != '0));

    desc_fifo #(
        .WIDTH($bits(desc_dma_pkg::track_t)),
        .DEPTH(`DESC_TRACK_DEPTH)
    ) u_track_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wr_en_i  (buf_pop_o),
        .wr_data_i(buf_entry_i.track),
        .rd_en_i  (trk_pop),
        .rd_data_o(trk_head),
        .full_o   (trk_full),
        .empty_o  (trk_empty)
    );

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_valid_q <= 1'b0;
            done_cnt_q  <= '0;
            wb_valid_q  <= 1'b0;
        end else begin
            if (buf_pop_o) begin
                req_valid_q <= 1'b1;
            end else if (dma_req_ready_i) begin
                req_valid_q <= 1'b0;
            end
            done_cnt_q <= done_cnt_q + DONE_W'(dma_done_i) - DONE_W'(trk_pop);
            if (trk_pop) begin
                wb_valid_q <= 1'b1;
            end else if (wb_ready_i) begin
                wb_valid_q <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        if (buf_pop_o) begin
            req_q <= buf_entry_i.req;
        end
        if (trk_pop) begin
            wb_addr_q <= trk_head.desc_addr;
            wb_irq_q  <= trk_head.irq;
        end
    end

    assign dma_req_valid_o = req_valid_q;
    assign dma_req_src_o   = req_q.src;
    assign dma_req_dst_o   = req_q.dst;
    assign dma_req_len_o   = req_q.len;

    assign wb_valid_o = wb_valid_q;
    assign wb_addr_o  = wb_addr_q;
    // interrupt exactly on the accepted writeback
    assign irq_o      = wb_valid_q && wb_ready_i && wb_irq_q;

    assign busy_o = req_valid_q || !trk_empty || wb_valid_q;

endmodule

//--- design/desc_dma_consts.svh
// shared constants for the descriptor DMA front end
// include wherever a width, depth or descriptor field position is needed
`ifndef DESC_DMA_CONSTS_SVH
`define DESC_DMA_CONSTS_SVH

// address and length widths
`define DESC_ADDR_W 64
`define DESC_LEN_W 32

// a descriptor is fetched as four 64-bit beats
`define DESC_BEATS 4

// next address of all ones terminates a chain
`define DESC_END_ADDR {`DESC_ADDR_W{1'b1}}

// bit of the flags word that requests an interrupt on completion
`define DESC_FLAG_IRQ 0

// submission queue entries
`define DESC_QUEUE_DEPTH 4
// request buffer entries, also the fetcher's starting credit count
`define DESC_REQ_DEPTH 4
// copy requests allowed outstanding at the engine
`define DESC_TRACK_DEPTH 4

`endif

//--- design/desc_dma_frontend_top.sv
// top level of the descriptor-chain front end
// software pushes descriptor addresses; the chain is fetched, dispatched and written back
`timescale 1ns/1ps
`include "desc_dma_consts.svh"

module desc_dma_frontend_top (
    input  logic                clk_i,
    input  logic                rst_i,
    // submission queue
    input  desc_dma_pkg::addr_t desc_addr_i,
    input  logic                desc_addr_valid_i,
    output logic                desc_addr_ready_o,
    // descriptor reads
    output logic                rd_req_valid_o,
    output desc_dma_pkg::addr_t rd_req_addr_o,
    input  logic                rd_req_ready_i,
    input  logic                rd_rsp_valid_i,
    input  logic [63:0]         rd_rsp_data_i,
    // DMA engine
    output logic                dma_req_valid_o,
    output desc_dma_pkg::addr_t dma_req_src_o,
    output desc_dma_pkg::addr_t dma_req_dst_o,
    output desc_dma_pkg::len_t  dma_req_len_o,
    input  logic                dma_req_ready_i,
    input  logic                dma_done_i,
    // completion writeback
    output logic                wb_valid_o,
    output desc_dma_pkg::addr_t wb_addr_o,
    input  logic                wb_ready_i,
    output logic                irq_o,
    // status
    output logic                busy_o,
    output logic                queue_full_o
);

    desc_dma_pkg::addr_t      q_head;
    logic                     q_full;
    logic                     q_empty;
    logic                     q_pop;
    desc_dma_pkg::addr_t      cur_addr;
    desc_dma_pkg::addr_t      next_addr;
    logic                     next_valid;
    logic                     credit_ret;
    logic                     fetch_busy;
    desc_dma_pkg::buf_entry_t entry;
    logic                     entry_valid;
    desc_dma_pkg::buf_entry_t buf_head;
    logic                     buf_empty;
    logic                     buf_pop;
    logic                     cmp_busy;

    assign desc_addr_ready_o = !q_full;
    assign queue_full_o      = q_full;

    desc_fifo #(
        .WIDTH($bits(desc_dma_pkg::addr_t)),
        .DEPTH(`DESC_QUEUE_DEPTH)
    ) u_queue (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wr_en_i  (desc_addr_valid_i && desc_addr_ready_o),
        .wr_data_i(desc_addr_i),
        .rd_en_i  (q_pop),
        .rd_data_o(q_head),
        .full_o   (q_full),
        .empty_o  (q_empty)
    );

    desc_fetcher u_fetcher (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .queue_addr_i  (q_head),
        .queue_empty_i (q_empty),
        .queue_pop_o   (q_pop),
        .rd_req_valid_o(rd_req_valid_o),
        .rd_req_addr_o (rd_req_addr_o),
        .rd_req_ready_i(rd_req_ready_i),
        .next_addr_i   (next_addr),
        .next_valid_i  (next_valid),
        .credit_ret_i  (credit_ret),
        .cur_addr_o    (cur_addr),
        .busy_o        (fetch_busy)
    );

    desc_reader u_reader (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .rd_rsp_valid_i(rd_rsp_valid_i),
        .rd_rsp_data_i (rd_rsp_data_i),
        .cur_addr_i    (cur_addr),
        .entry_o       (entry),
        .entry_valid_o (entry_valid),
        .next_addr_o   (next_addr),
        .next_valid_o  (next_valid)
    );

    // credits guarantee a free slot for every push, so full is not needed
    desc_fifo #(
        .WIDTH($bits(desc_dma_pkg::buf_entry_t)),
        .DEPTH(`DESC_REQ_DEPTH)
    ) u_req_buf (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wr_en_i  (entry_valid),
        .wr_data_i(entry),
        .rd_en_i  (buf_pop),
        .rd_data_o(buf_head),
        .full_o   (),
        .empty_o  (buf_empty)
    );

    desc_completion u_completion (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .buf_entry_i    (buf_head),
        .buf_empty_i    (buf_empty),
        .buf_pop_o      (buf_pop),
        .credit_ret_o   (credit_ret),
        .dma_req_valid_o(dma_req_valid_o),
        .dma_req_src_o  (dma_req_src_o),
        .dma_req_dst_o  (dma_req_dst_o),
        .dma_req_len_o  (dma_req_len_o),
        .dma_req_ready_i(dma_req_ready_i),
        .dma_done_i     (dma_done_i),
        .wb_valid_o     (wb_valid_o),
        .wb_addr_o      (wb_addr_o),
        .wb_ready_i     (wb_ready_i),
        .irq_o          (irq_o),
        .busy_o         (cmp_busy)
    );

    // anything queued, fetching, buffered or awaiting completion
    assign busy_o = fetch_busy || !q_empty || !buf_empty || cmp_busy;

endmodule

//--- design/desc_dma_pkg.sv
// shared types of the descriptor DMA front end
// modules refer to these by scoped name
`include "desc_dma_consts.svh"

package desc_dma_pkg;

    typedef logic [`DESC_ADDR_W-1:0] addr_t;
    typedef logic [`DESC_LEN_W-1:0] len_t;

    // one copy request as handed to the engine
    typedef struct packed {
        addr_t src;
        addr_t dst;
        len_t  len;
    } dma_req_t;

    // what completion needs to remember per request
    typedef struct packed {
        addr_t desc_addr;
        logic  irq;
    } track_t;

    // one slot of the request buffer
    typedef struct packed {
        dma_req_t req;
        track_t   track;
    } buf_entry_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ISSUE,
        FETCH_WAIT
    } fetch_state_e;

    // order matches the layout of a descriptor in memory
    typedef enum logic [$clog2(`DESC_BEATS)-1:0] {
        BEAT_FLAGS_LEN,
        BEAT_NEXT,
        BEAT_SRC,
        BEAT_DST
    } beat_e;

endpackage

//--- design/desc_fetcher.sv
// picks the next descriptor address and issues its memory read
// chain addresses win over the submission queue; one fetch in flight at a time
// a fetch is only started while a request-buffer credit is held
`timescale 1ns/1ps
`include "desc_dma_consts.svh"

module desc_fetcher (
    input  logic                clk_i,
    input  logic                rst_i,
    input  desc_dma_pkg::addr_t queue_addr_i,
    input  logic                queue_empty_i,
    output logic                queue_pop_o,
    output logic                rd_req_valid_o,
    output desc_dma_pkg::addr_t rd_req_addr_o,
    input  logic                rd_req_ready_i,
    input  desc_dma_pkg::addr_t next_addr_i,
    input  logic                next_valid_i,
    input  logic                credit_ret_i,
    output desc_dma_pkg::addr_t cur_addr_o,
    output logic                busy_o
);

    localparam int unsigned CREDIT_W = $clog2(`DESC_REQ_DEPTH + 1);

    desc_dma_pkg::fetch_state_e state_q;
    desc_dma_pkg::addr_t        addr_q;
    desc_dma_pkg::addr_t        chain_addr_q;
    logic                       chain_valid_q;
    logic [CREDIT_W-1:0]        credits_q;
    logic                       take;

    // a new descriptor is chosen in idle when a credit and an address exist
    assign take = (state_q == desc_dma_pkg::FETCH_IDLE) && (credits_q != '0) &&
                  (chain_valid_q || !queue_empty_i);

    // queue head is only consumed when no chain is pending
    assign queue_pop_o = take && !chain_valid_q;

    assign rd_req_valid_o = (state_q == desc_dma_pkg::FETCH_ISSUE);
    assign rd_req_addr_o  = addr_q;
    // reader stamps the entry with this, stable until next_valid
    assign cur_addr_o     = addr_q;

    assign busy_o = (state_q != desc_dma_pkg::FETCH_IDLE) || chain_valid_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q       <= desc_dma_pkg::FETCH_IDLE;
            chain_valid_q <= 1'b0;
            credits_q     <= CREDIT_W'(`DESC_REQ_DEPTH);
        end else begin
            case (state_q)
                desc_dma_pkg::FETCH_IDLE: begin
                    if (take) begin
                        state_q <= desc_dma_pkg::FETCH_ISSUE;
                    end
                end
                desc_dma_pkg::FETCH_ISSUE: begin
                    // hold the read until memory takes it
                    if (rd_req_ready_i) begin
                        state_q <= desc_dma_pkg::FETCH_WAIT;
                    end
                end
                desc_dma_pkg::FETCH_WAIT: begin
                    // reader signals the end of the four beats
                    if (next_valid_i) begin
                        state_q <= desc_dma_pkg::FETCH_IDLE;
                    end
                end
                default: begin
                    state_q <= desc_dma_pkg::FETCH_IDLE;
                end
            endcase

            // pending chain address, cleared when it is used
            if (take && chain_valid_q) begin
                chain_valid_q <= 1'b0;
            end else if (next_valid_i) begin
                chain_valid_q <= (next_addr_i != `DESC_END_ADDR);
            end

            // returns and spends can land in the same cycle
            credits_q <= credits_q + CREDIT_W'(credit_ret_i) - CREDIT_W'(take);
        end
    end

    // address registers
    always_ff @(posedge clk_i) begin
        if (take) begin
            addr_q <= chain_valid_q ? chain_addr_q : queue_addr_i;
        end
        if (next_valid_i) begin
            chain_addr_q <= next_addr_i;
        end
    end

endmodule

//--- design/desc_fifo.sv
// synchronous circular FIFO with show-ahead output
// a write lands at the output one cycle later; read and write may share a cycle
`timescale 1ns/1ps

module desc_fifo #(
    parameter int unsigned WIDTH = 64,
    parameter int unsigned DEPTH = 4
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             wr_en_i,
    input  logic [WIDTH-1:0] wr_data_i,
    input  logic             rd_en_i,
    output logic [WIDTH-1:0] rd_data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_wr;
    logic             do_rd;

    // requests against a full or empty buffer are ignored
    assign do_wr = wr_en_i && !full_o;
    assign do_rd = rd_en_i && !empty_o;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);

    // head entry comes straight from the storage registers
    assign rd_data_o = mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // net change of one, or none when both happen
            count_q <= count_q + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

endmodule

//--- design/desc_reader.sv
// assembles the four response beats of a descriptor
// the cycle after the last beat it pushes a buffer entry and reports the next address
`timescale 1ns/1ps
`include "desc_dma_consts.svh"

module desc_reader (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     rd_rsp_valid_i,
    input  logic [63:0]              rd_rsp_data_i,
    input  desc_dma_pkg::addr_t      cur_addr_i,
    output desc_dma_pkg::buf_entry_t entry_o,
    output logic                     entry_valid_o,
    output desc_dma_pkg::addr_t      next_addr_o,
    output logic                     next_valid_o
);

    desc_dma_pkg::beat_e beat_q;
    logic                done_q;
    desc_dma_pkg::len_t  len_q;
    logic                irq_q;
    desc_dma_pkg::addr_t next_q;
    desc_dma_pkg::addr_t src_q;
    desc_dma_pkg::addr_t dst_q;

    // beat position and the one-cycle completion pulse
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            beat_q <= desc_dma_pkg::BEAT_FLAGS_LEN;
            done_q <= 1'b0;
        end else begin
            done_q <= rd_rsp_valid_i && (beat_q == desc_dma_pkg::BEAT_DST);
            if (rd_rsp_valid_i) begin
                case (beat_q)
                    desc_dma_pkg::BEAT_FLAGS_LEN: beat_q <= desc_dma_pkg::BEAT_NEXT;
                    desc_dma_pkg::BEAT_NEXT:      beat_q <= desc_dma_pkg::BEAT_SRC;
                    desc_dma_pkg::BEAT_SRC:       beat_q <= desc_dma_pkg::BEAT_DST;
                    default:                      beat_q <= desc_dma_pkg::BEAT_FLAGS_LEN;
                endcase
            end
        end
    end

    // descriptor fields
    always_ff @(posedge clk_i) begin
        if (rd_rsp_valid_i) begin
            case (beat_q)
                desc_dma_pkg::BEAT_FLAGS_LEN: begin
                    // flags low, length high; only the irq flag is kept
                    irq_q <= rd_rsp_data_i[`DESC_FLAG_IRQ];
                    len_q <= rd_rsp_data_i[63:32];
                end
                desc_dma_pkg::BEAT_NEXT: begin
                    next_q <= rd_rsp_data_i;
                end
                desc_dma_pkg::BEAT_SRC: begin
                    src_q <= rd_rsp_data_i;
                end
                default: begin
                    dst_q <= rd_rsp_data_i;
                end
            endcase
        end
    end

    assign entry_o.req.src         = src_q;
    assign entry_o.req.dst         = dst_q;
    assign entry_o.req.len         = len_q;
    // fetcher holds the descriptor address until next_valid
    assign entry_o.track.desc_addr = cur_addr_i;
    assign entry_o.track.irq       = irq_q;
    assign entry_valid_o           = done_q;

    assign next_addr_o  = next_q;
    assign next_valid_o = done_q;

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the descriptor DMA front end testbench with Verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_desc_dma \
    -o sim_tb > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0

//--- test/tb_desc_dma.sv
// testbench for the descriptor DMA front end
// models descriptor memory and the copy engine, builds the expected request order
// from the chains in memory and compares every fetch, request and writeback
`timescale 1ns/1ps
`include "desc_dma_consts.svh"

module tb_desc_dma;

    localparam logic [31:0] SEED = 32'hf986b18f;
    // upper bound on descriptors over all tests, sizes the watchdog
    localparam int MAX_DESC = 43;
    localparam int TIMEOUT_CYCLES = MAX_DESC * 400;
    localparam logic [63:0] DESC_BASE = 64'h0000_0040_0000_0000;

    // one expected copy request with its completion info
    typedef struct packed {
        desc_dma_pkg::addr_t src;
        desc_dma_pkg::addr_t dst;
        desc_dma_pkg::len_t  len;
        desc_dma_pkg::addr_t daddr;
        logic                irq;
    } exp_t;

    logic                clk_i = 1'b0;
    logic                rst_i;
    desc_dma_pkg::addr_t desc_addr_i;
    logic                desc_addr_valid_i;
    logic                desc_addr_ready_o;
    logic                rd_req_valid_o;
    desc_dma_pkg::addr_t rd_req_addr_o;
    logic                rd_req_ready_i;
    logic                rd_rsp_valid_i;
    logic [63:0]         rd_rsp_data_i;
    logic                dma_req_valid_o;
    desc_dma_pkg::addr_t dma_req_src_o;
    desc_dma_pkg::addr_t dma_req_dst_o;
    desc_dma_pkg::len_t  dma_req_len_o;
    logic                dma_req_ready_i;
    logic                dma_done_i;
    logic                wb_valid_o;
    desc_dma_pkg::addr_t wb_addr_o;
    logic                wb_ready_i;
    logic                irq_o;
    logic                busy_o;
    logic                queue_full_o;

    // descriptor memory, byte addressed, one 64-bit word per entry
    logic [63:0]         mem [logic [63:0]];
    exp_t                exp_req[$];
    exp_t                exp_wb[$];
    desc_dma_pkg::addr_t exp_fetch[$];
    // accepted reads waiting for their beats
    desc_dma_pkg::addr_t pending_reads[$];
    // cycle numbers at which the engine reports done, in order
    int                  done_due[$];

    int                  cycle = 0;
    int                  stall_pct = 0;
    logic                hold_dma = 1'b0;
    int                  err_mon = 0;
    int                  err_seq = 0;
    int                  next_slot = 0;
    // separate generators per process keep the draws in a fixed order
    logic [31:0]         data_rng = SEED;
    logic [31:0]         drive_rng = SEED;
    logic [31:0]         engine_rng = SEED;

    desc_dma_frontend_top u_dut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .desc_addr_i      (desc_addr_i),
        .desc_addr_valid_i(desc_addr_valid_i),
        .desc_addr_ready_o(desc_addr_ready_o),
        .rd_req_valid_o   (rd_req_valid_o),
        .rd_req_addr_o    (rd_req_addr_o),
        .rd_req_ready_i   (rd_req_ready_i),
        .rd_rsp_valid_i   (rd_rsp_valid_i),
        .rd_rsp_data_i    (rd_rsp_data_i),
        .dma_req_valid_o  (dma_req_valid_o),
        .dma_req_src_o    (dma_req_src_o),
        .dma_req_dst_o    (dma_req_dst_o),
        .dma_req_len_o    (dma_req_len_o),
        .dma_req_ready_i  (dma_req_ready_i),
        .dma_done_i       (dma_done_i),
        .wb_valid_o       (wb_valid_o),
        .wb_addr_o        (wb_addr_o),
        .wb_ready_i       (wb_ready_i),
        .irq_o            (irq_o),
        .busy_o           (busy_o),
        .queue_full_o     (queue_full_o)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] lcg_step(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // true with roughly pct percent probability
    function automatic bit chance(inout logic [31:0] state, input int pct);
        logic [31:0] r;
        r = lcg_step(state);
        return int'((r >> 8) % 32'd100) < pct;
    endfunction

    // walk a chain in memory: flags/len, next, src, dst at offsets 0, 8, 16, 24
    function automatic void build_expected(input desc_dma_pkg::addr_t head);
        desc_dma_pkg::addr_t a;
        exp_t                e;
        logic [63:0]         w0;
        int                  guard;
        a = head;
        guard = 0;
        while (a != `DESC_END_ADDR && guard < 64) begin
            w0 = mem[a];
            e.len = w0[63:32];
            e.irq = w0[`DESC_FLAG_IRQ];
            e.src = mem[a + 64'd16];
            e.dst = mem[a + 64'd24];
            e.daddr = a;
            exp_fetch.push_back(a);
            exp_req.push_back(e);
            exp_wb.push_back(e);
            a = mem[a + 64'd8];
            guard++;
        end
    endfunction

    // lay out n linked descriptors in fresh slots, bit i of irq_mask for descriptor i
    task automatic make_chain(input int n, input logic [3:0] irq_mask,
                              output desc_dma_pkg::addr_t head);
        desc_dma_pkg::addr_t a;
        desc_dma_pkg::addr_t nxt;
        logic [31:0]         flags;
        int                  i;
        head = DESC_BASE + 64'(next_slot) * 64'd64;
        for (i = 0; i < n; i++) begin
            a = DESC_BASE + 64'(next_slot) * 64'd64;
            next_slot++;
            nxt = (i == n - 1) ? `DESC_END_ADDR : a + 64'd64;
            // other flag bits get random junk
            flags = lcg_step(data_rng);
            flags[`DESC_FLAG_IRQ] = irq_mask[i];
            mem[a] = {lcg_step(data_rng), flags};
            mem[a + 64'd8] = nxt;
            mem[a + 64'd16] = {lcg_step(data_rng), lcg_step(data_rng)};
            mem[a + 64'd24] = {lcg_step(data_rng), lcg_step(data_rng)};
        end
    endtask

    // called and returns 1 ns after a rising edge
    task automatic push_addr(input desc_dma_pkg::addr_t a);
        build_expected(a);
        desc_addr_i = a;
        desc_addr_valid_i = 1'b1;
        @(negedge clk_i);
        while (!desc_addr_ready_o) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        desc_addr_valid_i = 1'b0;
    endtask

    // until every expected request and writeback has been seen
    task automatic wait_drain();
        do begin
            @(posedge clk_i);
        end while (exp_wb.size() != 0 || exp_req.size() != 0 || done_due.size() != 0);
        #1;
    endtask

    // memory, engine and ready stalls, driven 1 ns after the edge
    initial begin : model_drive
        desc_dma_pkg::addr_t rd_addr;
        int                  rd_left;
        rd_req_ready_i = 1'b0;
        rd_rsp_valid_i = 1'b0;
        rd_rsp_data_i = '0;
        dma_req_ready_i = 1'b0;
        dma_done_i = 1'b0;
        wb_ready_i = 1'b0;
        rd_addr = '0;
        rd_left = 0;
        forever begin
            @(posedge clk_i);
            #1;
            cycle++;
            rd_req_ready_i = !chance(drive_rng, stall_pct);
            dma_req_ready_i = !hold_dma && !chance(drive_rng, stall_pct);
            wb_ready_i = !chance(drive_rng, stall_pct);
            if (rd_left == 0 && pending_reads.size() != 0) begin
                rd_addr = pending_reads.pop_front();
                rd_left = `DESC_BEATS;
            end
            // beats with random gaps
            rd_rsp_valid_i = 1'b0;
            if (rd_left != 0 && !chance(drive_rng, stall_pct)) begin
                rd_rsp_valid_i = 1'b1;
                rd_rsp_data_i = mem[rd_addr + 64'(8 * (`DESC_BEATS - rd_left))];
                rd_left--;
            end
            dma_done_i = 1'b0;
            if (done_due.size() != 0 && done_due[0] <= cycle) begin
                dma_done_i = 1'b1;
                void'(done_due.pop_front());
            end
        end
    end

    // handshakes seen at the falling edge complete at the next rising edge
    always @(negedge clk_i) begin : compare_outputs
        exp_t                e;
        desc_dma_pkg::addr_t a;
        int                  due;
        if (!rst_i) begin
            if (rd_req_valid_o && rd_req_ready_i) begin
                pending_reads.push_back(rd_req_addr_o);
                assert (exp_fetch.size() != 0) else begin
                    err_mon++;
                    $display("descriptor fetch from %h at %0t ns with nothing left to fetch",
                             rd_req_addr_o, $time);
                end
                if (exp_fetch.size() != 0) begin
                    a = exp_fetch.pop_front();
                    assert (rd_req_addr_o == a) else begin
                        err_mon++;
                        $display("error at %0t ns: fetch address %h, expected %h",
                                 $time, rd_req_addr_o, a);
                    end
                end
            end
            if (dma_req_valid_o && dma_req_ready_i) begin
                assert (exp_req.size() != 0) else begin
                    err_mon++;
                    $display("DMA request at %0t ns with no descriptor outstanding", $time);
                end
                if (exp_req.size() != 0) begin
                    e = exp_req.pop_front();
                    assert (dma_req_src_o == e.src && dma_req_dst_o == e.dst &&
                            dma_req_len_o == e.len) else begin
                        err_mon++;
                        $display("error at %0t ns: request %h %h %h, expected %h %h %h",
                                 $time, dma_req_src_o, dma_req_dst_o, dma_req_len_o,
                                 e.src, e.dst, e.len);
                    end
                end
                // engine finishes in order after a short random delay
                due = cycle + 1;
                if (stall_pct != 0) begin
                    due = due + int'(lcg_step(engine_rng) % 32'd16);
                end
                if (done_due.size() != 0 && due <= done_due[$]) begin
                    due = done_due[$] + 1;
                end
                done_due.push_back(due);
            end
            if (wb_valid_o && wb_ready_i) begin
                assert (exp_wb.size() != 0) else begin
                    err_mon++;
                    $display("writeback at %0t ns with no request outstanding", $time);
                end
                if (exp_wb.size() != 0) begin
                    e = exp_wb.pop_front();
                    assert (wb_addr_o == e.daddr && irq_o == e.irq) else begin
                        err_mon++;
                        $display("error at %0t ns: writeback %h irq %b, expected %h irq %b",
                                 $time, wb_addr_o, irq_o, e.daddr, e.irq);
                    end
                end
            end else begin
                assert (!irq_o) else begin
                    err_mon++;
                    $display("error at %0t ns: irq_o high outside a writeback", $time);
                end
            end
        end
    end

    initial begin : stimulus
        desc_dma_pkg::addr_t head;
        logic [3:0]          mask;
        int                  n;
        rst_i = 1'b1;
        desc_addr_i = '0;
        desc_addr_valid_i = 1'b0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        assert (!rd_req_valid_o && !dma_req_valid_o && !wb_valid_o && !irq_o && !busy_o &&
                !queue_full_o && desc_addr_ready_o) else begin
            err_seq++;
            $display("error at %0t ns: outputs not at their reset values", $time);
        end
        @(posedge clk_i);
        #1;

        // single descriptor without interrupt
        make_chain(1, 4'b0000, head);
        push_addr(head);
        wait_drain();

        // chain of three, irq on first and third
        make_chain(3, 4'b0101, head);
        push_addr(head);
        wait_drain();

        // chains pushed back to back
        make_chain(2, 4'b0010, head);
        push_addr(head);
        make_chain(1, 4'b0001, head);
        push_addr(head);
        make_chain(3, 4'b0100, head);
        push_addr(head);
        wait_drain();

        // random stalls and latencies everywhere
        // model settings change at the falling edge, away from the drive point
        @(negedge clk_i);
        stall_pct = 30;
        @(posedge clk_i);
        #1;
        repeat (6) begin
            n = 1 + int'(lcg_step(data_rng) % 32'd4);
            mask = 4'(lcg_step(data_rng));
            make_chain(n, mask, head);
            push_addr(head);
        end
        wait_drain();

        // engine refuses requests until buffer, credits and queue are used up
        @(negedge clk_i);
        stall_pct = 0;
        hold_dma = 1'b1;
        @(posedge clk_i);
        #1;
        repeat (9) begin
            make_chain(1, 4'b0000, head);
            push_addr(head);
        end
        n = 0;
        @(negedge clk_i);
        while (!queue_full_o && n < 100) begin
            @(negedge clk_i);
            n++;
        end
        assert (queue_full_o && !desc_addr_ready_o) else begin
            err_seq++;
            $display("error at %0t ns: queue_full_o %b ready %b under back-pressure",
                     $time, queue_full_o, desc_addr_ready_o);
        end
        hold_dma = 1'b0;
        wait_drain();
        @(negedge clk_i);
        assert (!busy_o) else begin
            err_seq++;
            $display("error at %0t ns: busy_o still high after the last writeback", $time);
        end

        // quiet period, any late duplicate shows up in the monitor
        repeat (20) @(posedge clk_i);
        assert (exp_fetch.size() == 0) else begin
            err_seq++;
            $display("%0d descriptor fetches never happened", exp_fetch.size());
        end

        $display("errors: monitor %0d, sequence %0d", err_mon, err_seq);
        if (err_mon == 0 && err_seq == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        $display("timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("errors: monitor %0d, sequence %0d", err_mon, err_seq);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/desc_dma_pkg.sv
design/desc_fifo.sv
design/desc_fetcher.sv
design/desc_reader.sv
design/desc_completion.sv
design/desc_dma_frontend_top.sv
test/tb_desc_dma.sv
